// ==== scr_mem_cfg_pkg.sv ====
// Scrambled word store configuration
// Widths, reset key material and the keystream rule shared by RTL and model

package scr_mem_cfg_pkg;

  // Store geometry
  parameter int unsigned AddrWidth = 6;
  parameter int unsigned DataWidth = 32;
  parameter int unsigned KeyWidth  = 32;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [KeyWidth-1:0]  key_t;
  typedef logic [KeyWidth-1:0]  nonce_t;

  // Key material loaded at reset
  parameter key_t   DefaultKey   = 32'h9e37_79b9;
  parameter nonce_t DefaultNonce = 32'h7f4a_7c15;

  //////////////////////////////
  // Keystream
  //////////////////////////////

  // Key XOR nonce rotated left by the word address modulo 32
  function automatic data_t keystream(key_t key, nonce_t nonce, addr_t addr);
    logic [4:0]  rot;
    logic [63:0] dbl;
    rot = 5'(addr);
    dbl = {nonce, nonce} << rot;
    // Upper half of the doubled word holds the rotated nonce
    return key ^ dbl[63:32];
  endfunction

endpackage

// ==== scr_mem_bus_pkg.sv ====
// Scrambled word store bus and pipeline types
// Host request and response payloads, internal stages and key FSM states

package scr_mem_bus_pkg;

  //////////////////////////////
  // Host side
  //////////////////////////////

  // Payload held stable while req is high
  typedef struct packed {
    logic                   we;
    scr_mem_cfg_pkg::addr_t addr;
    scr_mem_cfg_pkg::data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic                   rvalid;
    scr_mem_cfg_pkg::data_t rdata;
  } mem_rsp_t;

  //////////////////////////////
  // Pipeline stages
  //////////////////////////////

  // Request port to RAM bank
  typedef struct packed {
    logic                   valid;
    logic                   we;
    scr_mem_cfg_pkg::addr_t addr;
    scr_mem_cfg_pkg::data_t sdata;
    scr_mem_cfg_pkg::data_t ks;
  } bank_op_t;

  // RAM bank to response port
  typedef struct packed {
    logic                   valid;
    logic                   we;
    scr_mem_cfg_pkg::data_t word;
    scr_mem_cfg_pkg::data_t ks;
  } bank_rd_t;

  // Key controller states
  typedef enum logic [1:0] {
    KEY_VALID      = 2'd0,
    KEY_REQUESTING = 2'd1
  } key_state_e;

endpackage

// ==== scr_key_ctrl.sv ====
// Scramble key controller
// Holds key and nonce, requests a fresh key after an invalidate pulse

`timescale 1ns/10ps

module scr_key_ctrl #(
  parameter scr_mem_cfg_pkg::key_t   DefaultKey   = scr_mem_cfg_pkg::DefaultKey,
  parameter scr_mem_cfg_pkg::nonce_t DefaultNonce = scr_mem_cfg_pkg::DefaultNonce
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    inval_i,
  input  logic                    key_valid_i,
  input  scr_mem_cfg_pkg::key_t   key_i,
  input  scr_mem_cfg_pkg::nonce_t nonce_i,
  output logic                    key_req_o,
  output logic                    key_ok_o,
  output scr_mem_cfg_pkg::key_t   key_o,
  output scr_mem_cfg_pkg::nonce_t nonce_o
);

  scr_mem_bus_pkg::key_state_e state_q, state_d;
  scr_mem_cfg_pkg::key_t       key_q;
  scr_mem_cfg_pkg::nonce_t     nonce_q;
  logic                        load_key;

  always_comb begin
    state_d  = state_q;
    load_key = 1'b0;
    unique case (state_q)
      scr_mem_bus_pkg::KEY_VALID: begin
        if (inval_i) begin
          state_d = scr_mem_bus_pkg::KEY_REQUESTING;
        end
      end
      scr_mem_bus_pkg::KEY_REQUESTING: begin
        // key_valid_i only counts while a key is requested
        if (key_valid_i) begin
          state_d  = scr_mem_bus_pkg::KEY_VALID;
          load_key = 1'b1;
        end
      end
      default: state_d = scr_mem_bus_pkg::KEY_VALID;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= scr_mem_bus_pkg::KEY_VALID;
      key_q   <= DefaultKey;
      nonce_q <= DefaultNonce;
    end else begin
      state_q <= state_d;
      if (load_key) begin
        key_q   <= key_i;
        nonce_q <= nonce_i;
      end
    end
  end

  assign key_req_o = (state_q == scr_mem_bus_pkg::KEY_REQUESTING);
  assign key_ok_o  = (state_q == scr_mem_bus_pkg::KEY_VALID);
  assign key_o     = key_q;
  assign nonce_o   = nonce_q;

  // Requesting and usable key are exclusive
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(key_req_o && key_ok_o));

endmodule

// ==== scr_mem_req_port.sv ====
// Scrambled store request port
// Grants host accesses, scrambles write data and issues the bank operation

`timescale 1ns/10ps

module scr_mem_req_port #(
  parameter int unsigned AddrWidth = scr_mem_cfg_pkg::AddrWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  scr_mem_bus_pkg::mem_req_t req_data_i,
  output logic                      gnt_o,
  input  logic                      key_ok_i,
  input  scr_mem_cfg_pkg::key_t     key_i,
  input  scr_mem_cfg_pkg::nonce_t   nonce_i,
  output scr_mem_bus_pkg::bank_op_t op_o
);

  logic [AddrWidth-1:0]      word_addr;
  scr_mem_cfg_pkg::addr_t    op_addr;
  scr_mem_cfg_pkg::data_t    ks;
  logic                      op_valid_q;
  logic                      op_we_q;
  scr_mem_cfg_pkg::addr_t    op_addr_q;
  scr_mem_cfg_pkg::data_t    op_sdata_q;
  scr_mem_cfg_pkg::data_t    op_ks_q;

  // No access while the key is being replaced
  assign gnt_o = req_i & key_ok_i;

  //////////////////////////////
  // Keystream
  //////////////////////////////

  // Only the implemented address bits select a word
  assign word_addr = req_data_i.addr[AddrWidth-1:0];
  assign op_addr   = scr_mem_cfg_pkg::addr_t'(word_addr);
  assign ks        = scr_mem_cfg_pkg::keystream(key_i, nonce_i, op_addr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_valid_q <= 1'b0;
    end else begin
      op_valid_q <= gnt_o;
    end
  end

  // Operation payload, captured on grant
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      op_we_q    <= req_data_i.we;
      op_addr_q  <= op_addr;
      op_sdata_q <= req_data_i.wdata ^ ks;
      op_ks_q    <= ks;
    end
  end

  always_comb begin
    op_o.valid = op_valid_q;
    op_o.we    = op_we_q;
    op_o.addr  = op_addr_q;
    op_o.sdata = op_sdata_q;
    op_o.ks    = op_ks_q;
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_o |-> key_ok_i);

endmodule

// ==== scr_ram_bank.sv ====
// Scrambled RAM bank
// Single-port word RAM with a registered read stage carrying the keystream

`timescale 1ns/10ps

module scr_ram_bank #(
  parameter int unsigned AddrWidth = scr_mem_cfg_pkg::AddrWidth
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  scr_mem_bus_pkg::bank_op_t op_i,
  output scr_mem_bus_pkg::bank_rd_t rd_o
);

  localparam int unsigned Depth = 2 ** AddrWidth;

  scr_mem_cfg_pkg::data_t mem_q [Depth];
  logic [AddrWidth-1:0]   idx;
  logic                   wr_en;
  logic                   rd_en;

  logic                   rd_valid_q;
  logic                   rd_we_q;
  scr_mem_cfg_pkg::data_t rd_word_q;
  scr_mem_cfg_pkg::data_t rd_ks_q;

  assign idx   = op_i.addr[AddrWidth-1:0];
  assign wr_en = op_i.valid & op_i.we;
  assign rd_en = op_i.valid & ~op_i.we;

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Words are kept scrambled
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[idx] <= op_i.sdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_word_q <= mem_q[idx];
    end
  end

  //////////////////////////////
  // Read stage
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= op_i.valid;
    end
  end

  // Writes travel along too so each access gets its response
  always_ff @(posedge clk_i) begin
    if (op_i.valid) begin
      rd_we_q <= op_i.we;
      rd_ks_q <= op_i.ks;
    end
  end

  always_comb begin
    rd_o.valid = rd_valid_q;
    rd_o.we    = rd_we_q;
    rd_o.word  = rd_word_q;
    rd_o.ks    = rd_ks_q;
  end

endmodule

// ==== scr_mem_rsp_port.sv ====
// Scrambled store response port
// Descrambles read words, drives rvalid and tracks accesses in flight

`timescale 1ns/10ps

module scr_mem_rsp_port (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      accept_i,
  input  scr_mem_bus_pkg::bank_rd_t rd_i,
  input  logic                      key_req_i,
  output scr_mem_bus_pkg::mem_rsp_t rsp_o,
  output logic                      idle_o
);

  logic [1:0] cnt_q, cnt_d;

  // Write responses return zero data
  always_comb begin
    rsp_o.rvalid = rd_i.valid;
    if (rd_i.valid && !rd_i.we) begin
      rsp_o.rdata = rd_i.word ^ rd_i.ks;
    end else begin
      rsp_o.rdata = '0;
    end
  end

  //////////////////////////////
  // In-flight count
  //////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (accept_i && !rd_i.valid) begin
      cnt_d = cnt_q + 2'd1;
    end else if (!accept_i && rd_i.valid) begin
      cnt_d = cnt_q - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= 2'd0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Busy from the accept cycle until its response is gone
  assign idle_o = (cnt_q == 2'd0) & ~accept_i & ~key_req_i;

  // Responses only for accepted accesses
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_i.valid |-> (cnt_q != 2'd0));

  // Two stage pipeline bounds the outstanding accesses
  assert property (@(posedge clk_i) disable iff (!rst_ni) cnt_q <= 2'd2);

endmodule

// ==== scr_mem_top.sv ====
// Scrambled word store top level
// Host req/gnt/rvalid bus in front of a keystream scrambled RAM bank

`timescale 1ns/10ps

module scr_mem_top #(
  parameter int unsigned             AddrWidth    = scr_mem_cfg_pkg::AddrWidth,
  parameter scr_mem_cfg_pkg::key_t   DefaultKey   = scr_mem_cfg_pkg::DefaultKey,
  parameter scr_mem_cfg_pkg::nonce_t DefaultNonce = scr_mem_cfg_pkg::DefaultNonce
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Host bus
  input  logic                      req_i,
  input  scr_mem_bus_pkg::mem_req_t req_data_i,
  output logic                      gnt_o,
  output scr_mem_bus_pkg::mem_rsp_t rsp_o,
  // Key interface
  input  logic                      inval_i,
  input  logic                      key_valid_i,
  input  scr_mem_cfg_pkg::key_t     key_i,
  input  scr_mem_cfg_pkg::nonce_t   nonce_i,
  output logic                      key_req_o,
  output logic                      idle_o
);

  logic                      key_ok;
  scr_mem_cfg_pkg::key_t     key;
  scr_mem_cfg_pkg::nonce_t   nonce;
  scr_mem_bus_pkg::bank_op_t op;
  scr_mem_bus_pkg::bank_rd_t rd;
  logic                      accept;

  assign accept = req_i & gnt_o;

  scr_key_ctrl #(
    .DefaultKey  (DefaultKey),
    .DefaultNonce(DefaultNonce)
  ) u_key_ctrl (
    .clk_i,
    .rst_ni,
    .inval_i,
    .key_valid_i,
    .key_i,
    .nonce_i,
    .key_req_o,
    .key_ok_o(key_ok),
    .key_o   (key),
    .nonce_o (nonce)
  );

  scr_mem_req_port #(.AddrWidth(AddrWidth)) u_req_port (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_data_i,
    .gnt_o,
    .key_ok_i(key_ok),
    .key_i   (key),
    .nonce_i (nonce),
    .op_o    (op)
  );

  scr_ram_bank #(.AddrWidth(AddrWidth)) u_ram_bank (
    .clk_i,
    .rst_ni,
    .op_i(op),
    .rd_o(rd)
  );

  scr_mem_rsp_port u_rsp_port (
    .clk_i,
    .rst_ni,
    .accept_i (accept),
    .rd_i     (rd),
    .key_req_i(key_req_o),
    .rsp_o,
    .idle_o
  );

endmodule

// ==== tb_scr_mem_tasks.svh ====
// Testbench helpers for the scrambled word store
// Random numbers, value checks and host bus driving with bounded waits

`ifndef TB_SCR_MEM_TASKS_SVH
`define TB_SCR_MEM_TASKS_SVH

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits, the low ones repeat too soon
  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = next_rand();
    return addr_t'(r >> (32 - AddrWidth));
  endfunction

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_level(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic drive_request(input logic we, input addr_t addr, input data_t wdata);
    req_i            = 1'b1;
    req_data_i.we    = we;
    req_data_i.addr  = addr;
    req_data_i.wdata = wdata;
  endtask

  // Waits for the grant and books the response due 2 cycles later
  task automatic finish_access();
    int    n;
    addr_t a;
    data_t ks;
    n = 0;
    while (!gnt_o && n < GntTimeout) begin
      @(negedge clk_i);
      #1;
      n++;
    end
    if (!gnt_o) begin
      $display("Error at %0t: request to address %0d never granted", $time, req_data_i.addr);
      errors++;
    end else begin
      check_level("idle_o while accepting", idle_o, 1'b0);
      a  = req_data_i.addr;
      ks = scr_mem_cfg_pkg::keystream(model_key, model_nonce, a);
      if (req_data_i.we) begin
        model_mem[a] = req_data_i.wdata ^ ks;
        exp_data_q.push_back('0);
      end else begin
        exp_data_q.push_back(model_mem[a] ^ ks);
      end
      exp_cyc_q.push_back(cyc + 2);
    end
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  task automatic access(input logic we, input addr_t addr, input data_t wdata);
    drive_request(we, addr, wdata);
    #1;
    finish_access();
  endtask

  task automatic collect_responses();
    while (rsp_rd < rsp_wr) begin
      if (exp_data_q.size() == 0) begin
        $display("Error at %0t: response with no accepted access", $time);
        errors++;
      end else begin
        if (rsp_cyc[rsp_rd] != exp_cyc_q[0]) begin
          $display("Error at %0t: response in cycle %0d, due in cycle %0d",
                   $time, rsp_cyc[rsp_rd], exp_cyc_q[0]);
          errors++;
        end
        check_data("rdata", rsp_data[rsp_rd], exp_data_q.pop_front());
        void'(exp_cyc_q.pop_front());
      end
      rsp_rd++;
    end
    if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
      $display("Error at %0t: no response in cycle %0d", $time, exp_cyc_q[0]);
      errors++;
      void'(exp_data_q.pop_front());
      void'(exp_cyc_q.pop_front());
    end
  endtask

  task automatic wait_drain(input logic check_busy);
    int n;
    n = 0;
    #1;
    collect_responses();
    while (exp_data_q.size() != 0 && n < DrainTimeout) begin
      if (check_busy) begin
        check_level("idle_o with accesses in flight", idle_o, 1'b0);
      end
      @(negedge clk_i);
      #1;
      collect_responses();
      n++;
    end
    if (exp_data_q.size() != 0) begin
      $display("Error at %0t: %0d responses never arrived", $time, exp_data_q.size());
      errors++;
      exp_data_q.delete();
      exp_cyc_q.delete();
    end
    @(negedge clk_i);
  endtask

`endif

// ==== tb_scr_mem.sv ====
// Testbench for the scrambled word store
// Directed tests of the host bus, the key handshake and keystream scrambling

`timescale 1ns/10ps

module tb_scr_mem;

  typedef scr_mem_cfg_pkg::addr_t addr_t;
  typedef scr_mem_cfg_pkg::data_t data_t;

  localparam int unsigned AddrWidth    = scr_mem_cfg_pkg::AddrWidth;
  localparam int          GntTimeout   = 16;
  localparam int          DrainTimeout = 16;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      req_i;
  scr_mem_bus_pkg::mem_req_t req_data_i;
  logic                      gnt_o;
  scr_mem_bus_pkg::mem_rsp_t rsp_o;
  logic                      inval_i;
  logic                      key_valid_i;
  scr_mem_cfg_pkg::key_t     key_i;
  scr_mem_cfg_pkg::nonce_t   nonce_i;
  logic                      key_req_o;
  logic                      idle_o;

  // Model holds the words scrambled, as the bank should
  data_t                   model_mem [2**AddrWidth];
  scr_mem_cfg_pkg::key_t   model_key   = scr_mem_cfg_pkg::DefaultKey;
  scr_mem_cfg_pkg::nonce_t model_nonce = scr_mem_cfg_pkg::DefaultNonce;
  data_t                   exp_data_q [$];
  int                      exp_cyc_q [$];

  // Responses as recorded on the bus
  data_t rsp_data [256];
  int    rsp_cyc [256];
  int    rsp_wr = 0;
  int    rsp_rd = 0;

  logic [31:0] lcg_state = 32'hbd8a3594;
  int          cyc = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) cyc <= cyc + 1;

  // rsp_o comes from registers, so the falling edge sees it settled
  always @(negedge clk_i) begin
    if (rsp_o.rvalid) begin
      rsp_data[rsp_wr] <= rsp_o.rdata;
      rsp_cyc[rsp_wr]  <= cyc;
      rsp_wr           <= rsp_wr + 1;
    end
  end

  scr_mem_top #(
    .AddrWidth   (AddrWidth),
    .DefaultKey  (scr_mem_cfg_pkg::DefaultKey),
    .DefaultNonce(scr_mem_cfg_pkg::DefaultNonce)
  ) uut (
    .clk_i,
    .rst_ni,
    .req_i,
    .req_data_i,
    .gnt_o,
    .rsp_o,
    .inval_i,
    .key_valid_i,
    .key_i,
    .nonce_i,
    .key_req_o,
    .idle_o
  );

  `include "tb_scr_mem_tasks.svh"

  //////////////////////////////
  // Key handshake
  //////////////////////////////

  task automatic request_key();
    inval_i = 1'b1;
    @(negedge clk_i);
    inval_i = 1'b0;
    check_level("key_req_o after inval", key_req_o, 1'b1);
    check_level("idle_o while key requested", idle_o, 1'b0);
  endtask

  // Key request must drop on the edge that takes the new key
  task automatic load_key(input scr_mem_cfg_pkg::key_t k, input scr_mem_cfg_pkg::nonce_t n);
    key_i       = k;
    nonce_i     = n;
    key_valid_i = 1'b1;
    @(negedge clk_i);
    key_valid_i = 1'b0;
    check_level("key_req_o after new key", key_req_o, 1'b0);
    model_key   = k;
    model_nonce = n;
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("[DONE] %s with %0d errors", name, errors - err0);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_basic_rw();
    int    err0;
    addr_t a [8];
    err0 = errors;
    check_level("key_req_o after reset", key_req_o, 1'b0);
    check_level("idle_o after reset", idle_o, 1'b1);
    check_level("gnt_o without req", gnt_o, 1'b0);
    foreach (a[i]) begin
      a[i] = rand_addr();
      drive_request(1'b1, a[i], next_rand());
      #1;
      check_level("gnt_o follows req_i", gnt_o, 1'b1);
      finish_access();
      wait_drain(1'b0);
    end
    foreach (a[i]) begin
      access(1'b0, a[i], '0);
      wait_drain(1'b0);
    end
    report_test("basic_rw", err0);
  endtask

  task automatic test_back_to_back();
    int    err0;
    addr_t a [6];
    err0 = errors;
    foreach (a[i]) a[i] = rand_addr();
    foreach (a[i]) access(1'b1, a[i], next_rand());
    foreach (a[i]) access(1'b0, a[i], '0);
    wait_drain(1'b1);
    report_test("back_to_back", err0);
  endtask

  task automatic test_key_request();
    int    err0;
    addr_t a;
    err0 = errors;
    a = rand_addr();
    access(1'b1, a, next_rand());
    wait_drain(1'b0);
    request_key();
    drive_request(1'b0, a, '0);
    repeat (4) begin
      #1;
      check_level("gnt_o while key invalid", gnt_o, 1'b0);
      check_level("key_req_o while requesting", key_req_o, 1'b1);
      @(negedge clk_i);
    end
    load_key(next_rand(), next_rand());
    #1;
    finish_access();
    wait_drain(1'b0);
    report_test("key_request", err0);
  endtask

  // Old data reads as data ^ old keystream ^ new keystream
  task automatic test_rekey_data();
    int    err0;
    addr_t a [4];
    err0 = errors;
    foreach (a[i]) begin
      a[i] = rand_addr();
      access(1'b1, a[i], next_rand());
    end
    wait_drain(1'b0);
    request_key();
    load_key(next_rand(), next_rand());
    foreach (a[i]) access(1'b0, a[i], '0);
    wait_drain(1'b0);
    foreach (a[i]) access(1'b1, a[i], next_rand());
    foreach (a[i]) access(1'b0, a[i], '0);
    wait_drain(1'b0);
    report_test("rekey_data", err0);
  endtask

  task automatic test_stray_key_valid();
    int    err0;
    addr_t a;
    err0 = errors;
    a = rand_addr();
    access(1'b1, a, next_rand());
    wait_drain(1'b0);
    repeat (3) begin
      key_i       = next_rand();
      nonce_i     = next_rand();
      key_valid_i = 1'b1;
      @(negedge clk_i);
      key_valid_i = 1'b0;
      check_level("key_req_o after stray key", key_req_o, 1'b0);
      check_level("idle_o after stray key", idle_o, 1'b1);
    end
    access(1'b0, a, '0);
    wait_drain(1'b0);
    report_test("stray_key_valid", err0);
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_i       = 1'b0;
    req_data_i  = '0;
    inval_i     = 1'b0;
    key_valid_i = 1'b0;
    key_i       = '0;
    nonce_i     = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_basic_rw();
    test_back_to_back();
    test_key_request();
    test_rekey_data();
    test_stray_key_valid();
    #1;
    collect_responses();
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== scr_mem.f ====
+incdir+.
scr_mem_cfg_pkg.sv
scr_mem_bus_pkg.sv
scr_key_ctrl.sv
scr_mem_req_port.sv
scr_ram_bank.sv
scr_mem_rsp_port.sv
scr_mem_top.sv
tb_scr_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the scrambled word store testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f scr_mem.f --top-module tb_scr_mem -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_scr_mem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  exit 1
fi

if ! grep -q "Test completed successfully" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
